//--- src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// machine word and instruction word
`define DATA_W      32
`define INST_W      32

// register file index
`define REG_ADDR_W  5

// jal, bgezal and bltzal write here
`define LINK_REG    31

`endif

//--- src/isa_pkg.sv
`include "mips_defs.svh"

package isa_pkg;

	typedef logic [`DATA_W-1:0]     word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001,
		OP_J       = 6'b000010, OP_JAL    = 6'b000011,
		OP_BEQ     = 6'b000100, OP_BNE    = 6'b000101,
		OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111,
		OP_ADDI    = 6'b001000, OP_ADDIU  = 6'b001001,
		OP_SLTI    = 6'b001010, OP_SLTIU  = 6'b001011,
		OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101,
		OP_XORI    = 6'b001110, OP_LUI    = 6'b001111,
		OP_LW      = 6'b100011, OP_SW     = 6'b101011
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [5:0] {
		F_SLL  = 6'b000000, F_SRL  = 6'b000010, F_SRA  = 6'b000011,
		F_SLLV = 6'b000100, F_SRLV = 6'b000110, F_SRAV = 6'b000111,
		F_JR   = 6'b001000, F_JALR = 6'b001001,
		F_ADD  = 6'b100000, F_ADDU = 6'b100001, F_SUB  = 6'b100010, F_SUBU = 6'b100011,
		F_AND  = 6'b100100, F_OR   = 6'b100101, F_XOR  = 6'b100110, F_NOR  = 6'b100111,
		F_SLT  = 6'b101010, F_SLTU = 6'b101011
	} funct_e;

	// REGIMM rt field, bit 4 marks the linking forms
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000, RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000, RI_BGEZAL = 5'b10001
	} regimm_e;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'h00,
		ALU_AND    = 8'h24, ALU_OR     = 8'h25, ALU_XOR    = 8'h26, ALU_NOR    = 8'h27,
		ALU_SLL    = 8'h7c, ALU_SRL    = 8'h02, ALU_SRA    = 8'h03,
		ALU_SLT    = 8'h2a, ALU_SLTU   = 8'h2b,
		ALU_ADD    = 8'h20, ALU_ADDU   = 8'h21, ALU_SUB    = 8'h22, ALU_SUBU   = 8'h23,
		ALU_ADDI   = 8'h55, ALU_ADDIU  = 8'h56,
		ALU_J      = 8'h4f, ALU_JAL    = 8'h50, ALU_JR     = 8'h08, ALU_JALR   = 8'h09,
		ALU_BEQ    = 8'h51, ALU_BNE    = 8'h52, ALU_BLEZ   = 8'h53, ALU_BGTZ   = 8'h54,
		ALU_BLTZ   = 8'h40, ALU_BGEZ   = 8'h41, ALU_BLTZAL = 8'h4a, ALU_BGEZAL = 8'h4b,
		ALU_LW     = 8'he3, ALU_SW     = 8'heb
	} alu_op_e;

	// which result group execute hands on
	typedef enum logic [2:0] {
		SEL_NOP   = 3'b000, SEL_LOGIC = 3'b001, SEL_SHIFT = 3'b010,
		SEL_ARITH = 3'b100, SEL_JB    = 3'b110, SEL_LS    = 3'b111
	} alu_sel_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_J, BR_JR, BR_BEQ, BR_BNE,
		BR_BGTZ, BR_BLEZ, BR_BGEZ, BR_BLTZ
	} br_kind_e;

endpackage

//--- src/pipe_pkg.sv
`include "mips_defs.svh"

package pipe_pkg;

	import isa_pkg::*;

	// pending write of a later stage
	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} fwd_port_t;

	typedef struct packed {
		fwd_port_t port;
		logic      is_load;  // result only known after memory
	} ex_fwd_t;

	typedef struct packed {
		logic      re1;
		logic      re2;
		reg_addr_t raddr1;
		reg_addr_t raddr2;
	} rf_req_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		logic      we;
		reg_addr_t waddr;
		rf_req_t   rf_req;
		word_t     imm;
		br_kind_e  br_kind;
		logic      link;
	} decode_ctrl_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} branch_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     op1;
		word_t     op2;
		reg_addr_t waddr;
		logic      we;
		word_t     link_addr;
		logic      in_delay_slot;
	} id_ex_t;

	localparam decode_ctrl_t CTRL_NOP = '{
		alu_op:  ALU_NOP,
		alu_sel: SEL_NOP,
		br_kind: BR_NONE,
		default: '0
	};

	localparam id_ex_t ID_EX_BUBBLE = '{
		alu_op:  ALU_NOP,
		alu_sel: SEL_NOP,
		default: '0
	};

endpackage

//--- src/inst_decoder.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module inst_decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  word_t        inst_i,
	output decode_ctrl_t ctrl_o
);

	opcode_e     opcode;
	funct_e      funct;
	regimm_e     rt_code;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  shamt;
	logic [15:0] imm16;
	logic        legal;

	assign opcode  = opcode_e'(inst_i[`INST_W-1 -: 6]);
	assign rs      = inst_i[25:21];
	assign rt      = inst_i[20:16];
	assign rd      = inst_i[15:11];
	assign shamt   = inst_i[10:6];
	assign funct   = funct_e'(inst_i[5:0]);
	assign imm16   = inst_i[15:0];
	assign rt_code = regimm_e'(rt);

	function automatic alu_op_e special_op(input funct_e f);
		case (f)
			F_AND:          return ALU_AND;
			F_OR:           return ALU_OR;
			F_XOR:          return ALU_XOR;
			F_NOR:          return ALU_NOR;
			F_SLL, F_SLLV:  return ALU_SLL;
			F_SRL, F_SRLV:  return ALU_SRL;
			F_SRA, F_SRAV:  return ALU_SRA;
			F_ADD:          return ALU_ADD;
			F_ADDU:         return ALU_ADDU;
			F_SUB:          return ALU_SUB;
			F_SUBU:         return ALU_SUBU;
			F_SLT:          return ALU_SLT;
			F_SLTU:         return ALU_SLTU;
			F_JR:           return ALU_JR;
			F_JALR:         return ALU_JALR;
			default:        return ALU_NOP;
		endcase
	endfunction

	function automatic alu_op_e imm_op(input opcode_e op);
		case (op)
			OP_ANDI:         return ALU_AND;
			OP_ORI, OP_LUI:  return ALU_OR;
			OP_XORI:         return ALU_XOR;
			OP_ADDI:         return ALU_ADDI;
			OP_ADDIU:        return ALU_ADDIU;
			OP_SLTI:         return ALU_SLT;
			OP_SLTIU:        return ALU_SLTU;
			OP_LW:           return ALU_LW;
			default:         return ALU_NOP;
		endcase
	endfunction

	always_comb begin
		ctrl_o = CTRL_NOP;
		legal  = 1'b1;
		ctrl_o.rf_req.raddr1 = rs;
		ctrl_o.rf_req.raddr2 = rt;
		case (opcode)
			OP_SPECIAL: begin
				ctrl_o.alu_op     = special_op(funct);
				ctrl_o.we         = 1'b1;
				ctrl_o.waddr      = rd;
				ctrl_o.rf_req.re1 = 1'b1;
				ctrl_o.rf_req.re2 = 1'b1;
				case (funct)
					F_AND, F_OR, F_XOR, F_NOR:  ctrl_o.alu_sel = SEL_LOGIC;
					F_SLLV, F_SRLV, F_SRAV:     ctrl_o.alu_sel = SEL_SHIFT;
					F_SLL, F_SRL, F_SRA: begin
						ctrl_o.alu_sel    = SEL_SHIFT;
						ctrl_o.rf_req.re1 = 1'b0;  // shamt goes out as op1
						ctrl_o.imm        = word_t'(shamt);
					end
					F_ADD, F_ADDU, F_SUB, F_SUBU, F_SLT, F_SLTU: ctrl_o.alu_sel = SEL_ARITH;
					F_JR, F_JALR: begin
						ctrl_o.alu_sel    = SEL_JB;
						ctrl_o.rf_req.re2 = 1'b0;
						ctrl_o.br_kind    = BR_JR;
						ctrl_o.link       = (funct == F_JALR);
						ctrl_o.we         = (funct == F_JALR);
					end
					default: legal = 1'b0;
				endcase
			end
			OP_REGIMM: begin
				ctrl_o.alu_sel    = SEL_JB;
				ctrl_o.rf_req.re1 = 1'b1;
				ctrl_o.br_kind    = BR_BLTZ;
				if (rt_code == RI_BGEZ || rt_code == RI_BGEZAL) begin
					ctrl_o.br_kind = BR_BGEZ;
				end
				ctrl_o.link  = (rt_code == RI_BLTZAL || rt_code == RI_BGEZAL);
				ctrl_o.we    = ctrl_o.link;
				ctrl_o.waddr = reg_addr_t'(`LINK_REG);
				case (rt_code)
					RI_BLTZ:    ctrl_o.alu_op = ALU_BLTZ;
					RI_BGEZ:    ctrl_o.alu_op = ALU_BGEZ;
					RI_BLTZAL:  ctrl_o.alu_op = ALU_BLTZAL;
					RI_BGEZAL:  ctrl_o.alu_op = ALU_BGEZAL;
					default:    legal = 1'b0;
				endcase
			end
			OP_J, OP_JAL: begin
				ctrl_o.alu_sel = SEL_JB;
				ctrl_o.br_kind = BR_J;
				ctrl_o.alu_op  = ALU_J;
				if (opcode == OP_JAL) begin
					ctrl_o.alu_op = ALU_JAL;
					ctrl_o.link   = 1'b1;
					ctrl_o.we     = 1'b1;
					ctrl_o.waddr  = reg_addr_t'(`LINK_REG);
				end
			end
			OP_BEQ, OP_BNE: begin
				ctrl_o.alu_sel    = SEL_JB;
				ctrl_o.rf_req.re1 = 1'b1;
				ctrl_o.rf_req.re2 = 1'b1;
				ctrl_o.alu_op     = ALU_BEQ;
				ctrl_o.br_kind    = BR_BEQ;
				if (opcode == OP_BNE) begin
					ctrl_o.alu_op  = ALU_BNE;
					ctrl_o.br_kind = BR_BNE;
				end
			end
			OP_BGTZ, OP_BLEZ: begin
				ctrl_o.alu_sel    = SEL_JB;
				ctrl_o.rf_req.re1 = 1'b1;
				ctrl_o.alu_op     = ALU_BGTZ;
				ctrl_o.br_kind    = BR_BGTZ;
				if (opcode == OP_BLEZ) begin
					ctrl_o.alu_op  = ALU_BLEZ;
					ctrl_o.br_kind = BR_BLEZ;
				end
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_LW: begin
				ctrl_o.alu_op     = imm_op(opcode);
				ctrl_o.alu_sel    = SEL_ARITH;
				ctrl_o.we         = 1'b1;
				ctrl_o.waddr      = rt;
				ctrl_o.rf_req.re1 = 1'b1;
				ctrl_o.imm        = {{16{imm16[15]}}, imm16};
				if (opcode == OP_LW) begin
					ctrl_o.alu_sel = SEL_LS;  // op2 carries the offset
				end
				if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI) begin
					ctrl_o.alu_sel = SEL_LOGIC;
					ctrl_o.imm     = {16'b0, imm16};
				end
				if (opcode == OP_LUI) begin
					// no read, both operands hold the shifted value and the or passes it
					ctrl_o.alu_sel    = SEL_LOGIC;
					ctrl_o.rf_req.re1 = 1'b0;
					ctrl_o.imm        = {imm16, 16'b0};
				end
			end
			OP_SW: begin
				ctrl_o.alu_op     = ALU_SW;
				ctrl_o.alu_sel    = SEL_LS;
				ctrl_o.rf_req.re1 = 1'b1;
				ctrl_o.rf_req.re2 = 1'b1;
			end
			default: legal = 1'b0;
		endcase

		if (!legal) begin
			ctrl_o = CTRL_NOP;
		end
		if (!ctrl_o.we) begin
			ctrl_o.waddr = '0;
		end
		if (!ctrl_o.rf_req.re1) begin
			ctrl_o.rf_req.raddr1 = '0;
		end
		if (!ctrl_o.rf_req.re2) begin
			ctrl_o.rf_req.raddr2 = '0;
		end
	end

endmodule

//--- src/operand_forward.sv
`timescale 1ns/10ps

module operand_forward
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  decode_ctrl_t ctrl_i,
	input  ex_fwd_t      ex_fwd_i,
	input  fwd_port_t    mem_fwd_i,
	input  word_t        rf_rdata1_i,
	input  word_t        rf_rdata2_i,
	output word_t        op1_o,
	output word_t        op2_o,
	output logic         stall_o
);

	logic stall1;
	logic stall2;

	// one read port, the youngest pending write wins
	function automatic word_t pick(
		input  logic      re,
		input  reg_addr_t addr,
		input  word_t     rf_data,
		input  word_t     imm,
		input  ex_fwd_t   ex,
		input  fwd_port_t mem,
		output logic      stall
	);
		stall = 1'b0;
		if (!re) begin
			return imm;
		end
		if (ex.is_load && ex.port.waddr == addr) begin
			stall = 1'b1;  // load data not there yet
			return '0;
		end
		if (ex.port.we && ex.port.waddr == addr) begin
			return ex.port.wdata;
		end
		if (mem.we && mem.waddr == addr) begin
			return mem.wdata;
		end
		return rf_data;
	endfunction

	always_comb begin
		op1_o = pick(ctrl_i.rf_req.re1, ctrl_i.rf_req.raddr1, rf_rdata1_i, ctrl_i.imm,
			ex_fwd_i, mem_fwd_i, stall1);
		op2_o = pick(ctrl_i.rf_req.re2, ctrl_i.rf_req.raddr2, rf_rdata2_i, ctrl_i.imm,
			ex_fwd_i, mem_fwd_i, stall2);
	end

	assign stall_o = stall1 | stall2;

endmodule

//--- src/branch_unit.sv
`timescale 1ns/10ps

module branch_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  word_t        pc_i,
	input  word_t        inst_i,
	input  decode_ctrl_t ctrl_i,
	input  word_t        op1_i,
	input  word_t        op2_i,
	input  logic         stall_i,
	output branch_t      branch_o,
	output word_t        link_addr_o
);

	word_t pc_plus4;
	word_t br_offset;
	word_t target;
	logic  cond;
	logic  taken;

	assign pc_plus4  = pc_i + 32'd4;
	assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		cond   = 1'b0;
		target = pc_plus4 + br_offset;  // relative to the delay slot
		case (ctrl_i.br_kind)
			BR_J: begin
				cond   = 1'b1;
				target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
			end
			BR_JR: begin
				cond   = 1'b1;
				target = op1_i;
			end
			BR_BEQ:   cond = (op1_i == op2_i);
			BR_BNE:   cond = (op1_i != op2_i);
			BR_BGTZ:  cond = !op1_i[31] && (op1_i != '0);
			BR_BLEZ:  cond = op1_i[31] || (op1_i == '0);
			BR_BGEZ:  cond = !op1_i[31];
			BR_BLTZ:  cond = op1_i[31];
			default:  cond = 1'b0;
		endcase
	end

	// operands are stale while waiting on a load
	assign taken           = cond & ~stall_i;
	assign branch_o.taken  = taken;
	assign branch_o.target = taken ? target : '0;

	assign link_addr_o = ctrl_i.link ? pc_i + 32'd8 : '0;  // skip the delay slot

endmodule

//--- src/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n_i,
	input  logic         stall_i,
	input  decode_ctrl_t ctrl_i,
	input  word_t        op1_i,
	input  word_t        op2_i,
	input  word_t        link_addr_i,
	input  logic         in_delay_slot_i,
	output id_ex_t       id_ex_o
);

	id_ex_t next;

	assign next = '{
		alu_op:        ctrl_i.alu_op,
		alu_sel:       ctrl_i.alu_sel,
		op1:           op1_i,
		op2:           op2_i,
		waddr:         ctrl_i.waddr,
		we:            ctrl_i.we,
		link_addr:     link_addr_i,
		in_delay_slot: in_delay_slot_i
	};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_o <= ID_EX_BUBBLE;
		end else if (stall_i) begin
			id_ex_o <= ID_EX_BUBBLE;  // execute idles while decode retries
		end else begin
			id_ex_o <= next;
		end
	end

endmodule

//--- src/id_stage.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module id_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  logic      is_in_delayslot_i,
	input  ex_fwd_t   ex_fwd_i,
	input  fwd_port_t mem_fwd_i,
	input  word_t     rf_rdata1_i,
	input  word_t     rf_rdata2_i,
	output rf_req_t   rf_req_o,
	output logic      stall_o,
	output branch_t   branch_o,
	output id_ex_t    id_ex_o
);

	decode_ctrl_t       ctrl;
	word_t              op1;
	word_t              op2;
	logic [`DATA_W-1:0] link_addr;

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	// register file answers in the same cycle
	assign rf_req_o = ctrl.rf_req;

	operand_forward u_forward (
		.ctrl_i      (ctrl),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.rf_rdata1_i (rf_rdata1_i),
		.rf_rdata2_i (rf_rdata2_i),
		.op1_o       (op1),
		.op2_o       (op2),
		.stall_o     (stall_o)
	);

	branch_unit u_branch (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.ctrl_i      (ctrl),
		.op1_i       (op1),
		.op2_i       (op2),
		.stall_i     (stall_o),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.stall_i         (stall_o),
		.ctrl_i          (ctrl),
		.op1_i           (op1),
		.op2_i           (op2),
		.link_addr_i     (link_addr),
		.in_delay_slot_i (is_in_delayslot_i),
		.id_ex_o         (id_ex_o)
	);

endmodule

//--- verification/id_stage_props.sv
`timescale 1ns/10ps

module id_stage_props
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input logic    clk,
	input logic    arst_n_i,
	input logic    stall_o,
	input branch_t branch_o,
	input id_ex_t  id_ex_o
);

	// operands are not valid while waiting on a load
	no_branch_on_stall: assert property (
		@(posedge clk) disable iff (!arst_n_i) stall_o |-> !branch_o.taken
	) else $error("branch taken while stalled");

	bubble_after_stall: assert property (
		@(posedge clk) disable iff (!arst_n_i) stall_o |=> id_ex_o == ID_EX_BUBBLE
	) else $error("no bubble after a stall cycle");

	no_write_in_reset: assert property (
		@(posedge clk) !arst_n_i |-> !id_ex_o.we
	) else $error("write enabled during reset");

endmodule

bind id_stage id_stage_props u_props (
	.clk      (clk),
	.arst_n_i (arst_n_i),
	.stall_o  (stall_o),
	.branch_o (branch_o),
	.id_ex_o  (id_ex_o)
);

//--- verification/id_stage_tb.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module id_stage_tb
	import isa_pkg::*;
	import pipe_pkg::*;
;

	// reset, six tests and one flush cycle per test
	localparam int STIM_CYCLES = 4 + 1 + 4 * 26 + 4 + 5 + 8 * 8 + 4 + 6;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;
	localparam id_ex_t NOP_ID_EX = '{alu_op: ALU_NOP, alu_sel: SEL_NOP, default: '0};
	localparam word_t MULT_INST = 32'h0085_0018;

	logic      clk;
	logic      arst_n;
	word_t     pc;
	word_t     inst;
	logic      dslot;
	ex_fwd_t   ex_fwd;
	fwd_port_t mem_fwd;
	word_t     rd1;
	word_t     rd2;
	rf_req_t   rf_req;
	logic      stall;
	branch_t   br;
	id_ex_t    id_ex;

	id_ex_t exp_q[$];
	int     errors = 0;
	int     checks = 0;
	int     err_mark = 0;
	int     cycles = 0;

	logic [5:0] r_funct [16] = '{6'h24, 6'h25, 6'h26, 6'h27, 6'h00, 6'h02, 6'h03, 6'h04,
		6'h06, 6'h07, 6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b};
	logic [5:0] i_opc [10] = '{6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h08, 6'h09, 6'h0a, 6'h0b,
		6'h23, 6'h2b};
	logic [5:0] br_opc [8] = '{6'h04, 6'h05, 6'h07, 6'h06, 6'h01, 6'h01, 6'h01, 6'h01};
	logic [4:0] br_rt [8] = '{5'd6, 5'd6, 5'd0, 5'd0, 5'd0, 5'd1, 5'd16, 5'd17};

	id_stage u_dut (
		.clk               (clk),
		.arst_n_i          (arst_n),
		.pc_i              (pc),
		.inst_i            (inst),
		.is_in_delayslot_i (dslot),
		.ex_fwd_i          (ex_fwd),
		.mem_fwd_i         (mem_fwd),
		.rf_rdata1_i       (rd1),
		.rf_rdata2_i       (rd2),
		.rf_req_o          (rf_req),
		.stall_o           (stall),
		.branch_o          (br),
		.id_ex_o           (id_ex)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic word_t rtype(input logic [5:0] fn, input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t itype(input logic [5:0] opc, input reg_addr_t rs, input reg_addr_t rt,
		input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	// youngest pending write first, load in execute stalls
	function automatic word_t fwd_operand(input logic re, input reg_addr_t ad, input word_t rf,
		input word_t imm, input ex_fwd_t ex, input fwd_port_t mem, output logic st);
		st = 1'b0;
		if (!re) return imm;
		if (ex.is_load && ex.port.waddr == ad) begin
			st = 1'b1;
			return '0;
		end
		if (ex.port.we && ex.port.waddr == ad) return ex.port.wdata;
		if (mem.we && mem.waddr == ad) return mem.wdata;
		return rf;
	endfunction

	function automatic void ref_decode(input word_t i, input word_t pc_v, input word_t r1,
		input word_t r2, input ex_fwd_t ex, input fwd_port_t mem, input logic ds,
		output id_ex_t e, output branch_t b, output logic s, output rf_req_t rq);
		logic [5:0] opc;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  wa;
		logic       re1, re2, we, lnk, cond, s1, s2;
		int         kind;  // 1 j, 2 jr, 3 beq, 4 bne, 5 bgtz, 6 blez, 7 bgez, 8 bltz
		word_t      imm, a, c, tgt, pc4, la;
		alu_op_e    op;
		alu_sel_e   sel;
		opc = i[31:26];
		fn  = i[5:0];
		rs  = i[25:21];
		rt  = i[20:16];
		{re1, re2, we, lnk} = 4'b0;
		imm  = '0;
		wa   = rt;
		kind = 0;
		op   = ALU_NOP;
		sel  = SEL_NOP;
		case (opc)
			6'h00: begin
				{re1, re2, we} = 3'b111;
				wa = i[15:11];
				case (fn)
					6'h24, 6'h25, 6'h26, 6'h27: sel = SEL_LOGIC;
					6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07: sel = SEL_SHIFT;
					6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b: sel = SEL_ARITH;
					6'h08, 6'h09: sel = SEL_JB;
					default: sel = SEL_NOP;
				endcase
				op = alu_op_e'({2'b00, fn});  // funct code doubles as the operation
				if (sel == SEL_SHIFT) op = fn[1] ? (fn[0] ? ALU_SRA : ALU_SRL) : ALU_SLL;
				if (sel == SEL_SHIFT && !fn[2]) begin
					re1 = 1'b0;
					imm = {27'b0, i[10:6]};
				end
				if (sel == SEL_JB) begin
					re2  = 1'b0;
					kind = 2;
					lnk  = fn[0];
					we   = fn[0];
				end
			end
			6'h01: begin
				re1  = 1'b1;
				sel  = (rt[3:1] == 3'b000) ? SEL_JB : SEL_NOP;
				kind = rt[0] ? 7 : 8;
				lnk  = rt[4];
				we   = rt[4];
				wa   = 5'd`LINK_REG;
				op   = alu_op_e'(8'h40 + (rt[4] ? 8'h0a : 8'h00) + {7'b0, rt[0]});
			end
			6'h02, 6'h03: begin
				sel  = SEL_JB;
				kind = 1;
				op   = opc[0] ? ALU_JAL : ALU_J;
				lnk  = opc[0];
				we   = opc[0];
				wa   = 5'd`LINK_REG;
			end
			6'h04, 6'h05, 6'h06, 6'h07: begin
				sel  = SEL_JB;
				re1  = 1'b1;
				re2  = !opc[1];
				kind = opc[1] ? (opc[0] ? 5 : 6) : (opc[0] ? 4 : 3);
				op   = opc[1] ? (opc[0] ? ALU_BGTZ : ALU_BLEZ) : (opc[0] ? ALU_BNE : ALU_BEQ);
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h23: begin
				{re1, we} = 2'b11;
				sel = opc[5] ? SEL_LS : SEL_ARITH;
				imm = {{16{i[15]}}, i[15:0]};
				op  = opc[1] ? (opc[0] ? ALU_SLTU : ALU_SLT) : (opc[0] ? ALU_ADDIU : ALU_ADDI);
				if (opc[5]) op = ALU_LW;
			end
			6'h0c, 6'h0d, 6'h0e: begin
				{re1, we} = 2'b11;
				sel = SEL_LOGIC;
				imm = {16'b0, i[15:0]};
				op  = alu_op_e'({6'b001001, opc[1:0]});
			end
			6'h0f: begin
				we  = 1'b1;
				sel = SEL_LOGIC;
				imm = {i[15:0], 16'b0};
				op  = ALU_OR;
			end
			6'h2b: begin
				{re1, re2} = 2'b11;
				sel = SEL_LS;
				op  = ALU_SW;
			end
			default: sel = SEL_NOP;
		endcase
		if (sel == SEL_NOP) begin  // unsupported, decodes as a bubble
			{re1, re2, we, lnk} = 4'b0;
			imm  = '0;
			kind = 0;
			op   = ALU_NOP;
		end
		if (!we) wa = '0;
		a  = fwd_operand(re1, rs, r1, imm, ex, mem, s1);
		c  = fwd_operand(re2, rt, r2, imm, ex, mem, s2);
		s  = s1 | s2;
		rq = '{re1, re2, re1 ? rs : 5'd0, re2 ? rt : 5'd0};
		pc4  = pc_v + 32'd4;
		tgt  = pc4 + {{14{i[15]}}, i[15:0], 2'b00};
		case (kind)
			1, 2: cond = 1'b1;
			3: cond = (a == c);
			4: cond = (a != c);
			5: cond = !a[31] && a != '0;
			6: cond = a[31] || a == '0;
			7: cond = !a[31];
			8: cond = a[31];
			default: cond = 1'b0;
		endcase
		if (kind == 1) tgt = {pc4[31:28], i[25:0], 2'b00};
		if (kind == 2) tgt = a;
		b.taken  = cond && !s;
		b.target = b.taken ? tgt : '0;
		la = lnk ? pc_v + 32'd8 : '0;
		e  = s ? NOP_ID_EX : '{op, sel, a, c, wa, we, la, ds};
	endfunction

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error @%0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic apply(input word_t i, input word_t p, input word_t r1, input word_t r2,
		input ex_fwd_t ex, input fwd_port_t mem, input logic ds);
		id_ex_t  e;
		branch_t b;
		logic    s;
		rf_req_t rq;
		@(negedge clk);
		inst    = i;
		pc      = p;
		rd1     = r1;
		rd2     = r2;
		ex_fwd  = ex;
		mem_fwd = mem;
		dslot   = ds;
		@(posedge clk);
		ref_decode(i, p, r1, r2, ex, mem, ds, e, b, s, rq);
		check("stall_o", 128'(s), 128'(stall));
		check("branch_o", 128'(b), 128'(br));
		check("rf_req_o", 128'(rq), 128'(rf_req));
		exp_q.push_back(e);
	endtask

	task automatic finish_test(input string name);
		@(negedge clk);
		#1;
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// registered result one cycle after each stimulus
	always @(negedge clk) begin
		if (exp_q.size() > 0) check("id_ex_o", 128'(exp_q.pop_front()), 128'(id_ex));
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a test never finished", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		ex_fwd_t   ex_hit, ex_miss, ex_ld;
		fwd_port_t mem_hit, mem_miss;
		word_t     i, r1;
		void'($urandom(77));
		arst_n  = 1'b0;
		pc      = '0;
		inst    = itype(6'h09, 5'd1, 5'd2, 16'h1234);  // legal, would load without reset
		dslot   = 1'b1;
		ex_fwd  = '0;
		mem_fwd = '0;
		rd1     = '0;
		rd2     = '0;
		repeat (2) @(negedge clk);
		check("id_ex_o", 128'(NOP_ID_EX), 128'(id_ex));
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		apply(MULT_INST, $urandom, $urandom, $urandom, '0, '0, 1'b1);
		finish_test("reset and unsupported");

		repeat (4) begin
			foreach (r_funct[k]) begin
				i = rtype(r_funct[k], 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom));
				apply(i, $urandom, $urandom, $urandom, '0, '0, 1'b0);
			end
			foreach (i_opc[k]) begin
				i = itype(i_opc[k], 5'($urandom), 5'($urandom), 16'($urandom));
				apply(i, $urandom, $urandom, $urandom, '0, '0, 1'b0);
			end
		end
		finish_test("alu and immediate decode");

		ex_hit   = '{port: '{1'b1, 5'd5, $urandom}, is_load: 1'b0};
		ex_miss  = '{port: '{1'b1, 5'd9, $urandom}, is_load: 1'b0};
		mem_hit  = '{1'b1, 5'd5, $urandom};
		mem_miss = '{1'b1, 5'd12, $urandom};
		i = rtype(6'h21, 5'd5, 5'd6, 5'd3, 5'd0);
		apply(i, $urandom, $urandom, $urandom, ex_hit, mem_miss, 1'b0);
		apply(i, $urandom, $urandom, $urandom, ex_miss, mem_hit, 1'b0);
		apply(i, $urandom, $urandom, $urandom, ex_hit, mem_hit, 1'b0);
		apply(i, $urandom, $urandom, $urandom, ex_miss, mem_miss, 1'b0);
		finish_test("forwarding priority");

		ex_ld = '{port: '{1'b1, 5'd5, $urandom}, is_load: 1'b1};
		apply(rtype(6'h21, 5'd5, 5'd6, 5'd3, 5'd0), $urandom, $urandom, $urandom, ex_ld, '0, 1'b0);
		apply(rtype(6'h21, 5'd7, 5'd5, 5'd3, 5'd0), $urandom, $urandom, $urandom, ex_ld, '0, 1'b0);
		apply(rtype(6'h00, 5'd5, 5'd6, 5'd3, 5'd4), $urandom, $urandom, $urandom, ex_ld, '0, 1'b0);
		// jr always wants to jump, the stall must hold it back
		apply(rtype(6'h08, 5'd5, 5'd0, 5'd0, 5'd0), $urandom, $urandom, $urandom, ex_ld, '0, 1'b0);
		ex_ld.port.waddr = 5'd9;
		apply(rtype(6'h21, 5'd5, 5'd6, 5'd3, 5'd0), $urandom, $urandom, $urandom, ex_ld, '0, 1'b0);
		finish_test("load-use stall");

		repeat (8) begin
			foreach (br_opc[k]) begin
				i  = itype(br_opc[k], 5'($urandom), br_rt[k], 16'($urandom));
				r1 = ($urandom % 4 == 0) ? '0 : $urandom;
				apply(i, $urandom, r1, ($urandom % 2) ? r1 : $urandom, '0, '0, 1'($urandom));
			end
		end
		finish_test("conditional branches");

		apply({6'h02, 26'($urandom)}, $urandom, $urandom, $urandom, '0, '0, 1'b1);
		apply({6'h03, 26'($urandom)}, $urandom, $urandom, $urandom, '0, '0, 1'b1);
		apply(rtype(6'h08, 5'd8, 5'd0, 5'd0, 5'd0), $urandom, $urandom, $urandom, '0, '0, 1'b1);
		apply(rtype(6'h09, 5'd8, 5'd0, 5'd31, 5'd0), $urandom, $urandom, $urandom, '0, '0, 1'b1);
		finish_test("jumps and delay slot");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/inst_decoder.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_ex_reg.sv
src/id_stage.sv
verification/id_stage_props.sv
verification/id_stage_tb.sv

//--- run.sh
#!/bin/bash
# build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module id_stage_tb -f verilog.f -o sim_id_stage &&
./obj_dir/sim_id_stage | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" || { echo "FAIL"; exit 1; }
